// File: common/uart_baud_pkg.sv
`default_nettype none

package uart_baud_pkg;

	parameter int baud_select_width = 3;
	parameter int num_baud_rates = 2 ** baud_select_width;

	// --------------------
	// clock cycles per sample enable
	// --------------------
	// Entries are round(50 MHz / (16 * baud)) for a 50 MHz system clock
	parameter int unsigned sample_divisor_table [num_baud_rates] = '{
		326,  // 0: 9600 baud
		163,  // 1: 19200 baud
		81,   // 2: 38400 baud
		54,   // 3: 57600 baud
		27,   // 4: 115200 baud
		14,   // 5: 230400 baud
		7,    // 6: 460800 baud
		3     // 7: 921600 baud
	};

	// select 0 is the slowest rate and so the largest entry
	parameter int divisor_width = $clog2(sample_divisor_table[0] + 1);

endpackage

`default_nettype wire

// File: common/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

	// --------------------
	// character and frame layout
	// --------------------
	parameter int data_width = 8;       // bits per character
	parameter int frame_bits = 11;      // start, data, parity, stop
	parameter int oversample = 16;      // sample enables per bit

	parameter logic start_level = 1'b0;
	parameter logic stop_level = 1'b1;
	parameter logic idle_level = 1'b1;  // line state between frames

	parameter int parity_pos = frame_bits - 2;
	parameter int stop_pos = frame_bits - 1;

	// bit 0 goes out first, so the data sits in lsb-first order after the start bit
	function automatic logic [frame_bits-1:0] build_frame(
		input logic [data_width-1:0] char_data
	);
		logic [frame_bits-1:0] frame;
		frame = '0;
		frame[0] = start_level;
		frame[data_width:1] = char_data;
		frame[parity_pos] = ^char_data;  // even parity over the data bits
		frame[stop_pos] = stop_level;
		return frame;
	endfunction

endpackage

`default_nettype wire

// File: hdl/tx_status_collector.sv
`timescale 1ns/1ps
`default_nettype none

module tx_status_collector #(
	parameter int num_channels = 4
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [num_channels-1:0] busy,
	input  logic [num_channels-1:0] clear_done,
	output logic [num_channels-1:0] done,
	output logic                    irq
);

	logic [num_channels-1:0] busy_last;
	logic [num_channels-1:0] busy_fall;
	logic [num_channels-1:0] done_next;

	assign busy_fall = busy_last & ~busy;

	// a clear in the same cycle as a set only wins in that one bit
	assign done_next = (done | busy_fall) & ~clear_done;

	// --------------------
	// edge detect
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_last <= '0;
		end else begin
			busy_last <= busy;
		end
	end

	// --------------------
	// sticky flags
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			done <= '0;
		end else begin
			done <= done_next;
		end
	end

	// follows the flags one cycle late
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			irq <= 1'b0;
		end else begin
			irq <= |done;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tx_write_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tx_write_decoder #(
	parameter int num_channels = 4,
	parameter int chan_addr_width = 2
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  wr,
	input  logic [chan_addr_width-1:0]            addr,
	input  logic [uart_frame_pkg::data_width-1:0] data,
	output logic [num_channels-1:0]               chan_wr,
	output logic [uart_frame_pkg::data_width-1:0] chan_data,
	output logic                                  addr_error
);

	logic addr_valid;
	logic [num_channels-1:0] strobe;

	assign addr_valid = (int'(addr) < num_channels);

	always_comb begin
		strobe = '0;
		for (int i = 0; i < num_channels; i++) begin
			strobe[i] = wr && (int'(addr) == i);  // at most one bit set
		end
	end

	// --------------------
	// host write registers
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			chan_wr <= '0;
			addr_error <= 1'b0;
		end else begin
			chan_wr <= strobe;
			if (wr && !addr_valid) begin
				addr_error <= 1'b1;  // held until reset
			end
		end
	end

	// the byte is shared by all channels, only the strobe picks the target
	always_ff @(posedge clk) begin
		if (wr) begin
			chan_data <= data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/uart_baud_controller.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_controller (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [uart_baud_pkg::baud_select_width-1:0] baud_select,
	output logic                                   sample_enable
);
	import uart_baud_pkg::*;

	logic [divisor_width-1:0] count;
	logic [divisor_width-1:0] reload_value;
	logic [baud_select_width-1:0] last_select;
	logic select_changed;

	assign reload_value = divisor_width'(sample_divisor_table[baud_select] - 1);
	assign select_changed = (baud_select != last_select);

	// --------------------
	// divider
	// --------------------
	// a new select reloads at once so the old, possibly long, count is not run out
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			last_select <= '0;
			sample_enable <= 1'b0;
		end else begin
			last_select <= baud_select;
			if (select_changed) begin
				count <= reload_value;
				sample_enable <= 1'b0;
			end else if (count == '0) begin
				count <= reload_value;
				sample_enable <= 1'b1;  // one pulse per divisor period
			end else begin
				count <= count - divisor_width'(1);
				sample_enable <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/uart_tx_array.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_array #(
	parameter int num_channels = 4,
	parameter int chan_addr_width = 2
) (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       wr,
	input  logic [chan_addr_width-1:0]                 addr,
	input  logic [uart_frame_pkg::data_width-1:0]      data,
	input  logic [uart_baud_pkg::baud_select_width-1:0] baud_select,
	input  logic [num_channels-1:0]                    tx_en,
	input  logic [num_channels-1:0]                    clear_done,
	output logic [num_channels-1:0]                    tx_line,
	output logic [num_channels-1:0]                    busy,
	output logic [num_channels-1:0]                    done,
	output logic                                       irq,
	output logic                                       addr_error
);
	import uart_frame_pkg::*;

	logic sample_enable;
	logic [num_channels-1:0] chan_wr;
	logic [data_width-1:0] chan_data;

	uart_baud_controller u_baud_controller (
		.clk           (clk),
		.reset         (reset),
		.baud_select   (baud_select),
		.sample_enable (sample_enable)
	);

	tx_write_decoder #(
		.num_channels    (num_channels),
		.chan_addr_width (chan_addr_width)
	) u_write_decoder (
		.clk        (clk),
		.reset      (reset),
		.wr         (wr),
		.addr       (addr),
		.data       (data),
		.chan_wr    (chan_wr),
		.chan_data  (chan_data),
		.addr_error (addr_error)
	);

	// --------------------
	// transmit channels
	// --------------------
	for (genvar i = 0; i < num_channels; i++) begin : g_channel
		uart_tx_channel u_channel (
			.clk           (clk),
			.reset         (reset),
			.sample_enable (sample_enable),  // one strobe shared by every channel
			.tx_en         (tx_en[i]),
			.wr            (chan_wr[i]),
			.data          (chan_data),
			.tx_line       (tx_line[i]),
			.busy          (busy[i])
		);
	end

	tx_status_collector #(
		.num_channels (num_channels)
	) u_status_collector (
		.clk        (clk),
		.reset      (reset),
		.busy       (busy),
		.clear_done (clear_done),
		.done       (done),
		.irq        (irq)
	);

endmodule

`default_nettype wire

// File: project.f
common/uart_frame_pkg.sv
common/uart_baud_pkg.sv
hdl/uart_baud_controller.sv
uart_tx/uart_tx_channel.sv
hdl/tx_write_decoder.sv
hdl/tx_status_collector.sv
hdl/uart_tx_array.sv
verification/uart_tx_array_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the UART transmit array testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

top=uart_tx_array_tb
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
	-f project.f \
	--top-module "$top" \
	--Mdir "$build_dir"

"./$build_dir/V$top" | tee "$log"

if grep -q "Test passed" "$log"; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail, see $log"
	exit 1
fi

// File: uart_tx/uart_tx_channel.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_channel (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  sample_enable,
	input  logic                                  tx_en,
	input  logic                                  wr,
	input  logic [uart_frame_pkg::data_width-1:0] data,
	output logic                                  tx_line,
	output logic                                  busy
);
	import uart_frame_pkg::*;

	localparam int sample_width = $clog2(oversample);
	localparam int index_width = $clog2(frame_bits + 1);

	typedef enum logic {
		st_idle,
		st_sending
	} state_t;

	state_t state;
	logic [frame_bits-1:0] frame;
	logic [sample_width-1:0] sample_count;
	logic [index_width-1:0] bit_index;
	logic bit_tick;
	logic take_write;
	logic frame_done;

	assign take_write = wr && tx_en && (state == st_idle);
	assign bit_tick = sample_enable && (sample_count == sample_width'(oversample - 1));
	assign frame_done = (bit_index == index_width'(frame_bits));
	assign busy = (state == st_sending);

	// --------------------
	// bit timing
	// --------------------
	// free running while enabled, so a frame starts on the next tick after the write
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sample_count <= '0;
		end else if (!tx_en) begin
			sample_count <= '0;
		end else if (sample_enable) begin
			sample_count <= sample_count + sample_width'(1);  // wraps every bit
		end
	end

	// --------------------
	// frame register
	// --------------------
	always_ff @(posedge clk) begin
		if (take_write) begin
			frame <= build_frame(data);
		end
	end

	// --------------------
	// transmit FSM
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			bit_index <= '0;
			tx_line <= idle_level;
		end else begin
			case (state)
				st_idle: begin
					tx_line <= idle_level;
					bit_index <= '0;
					if (take_write) begin
						state <= st_sending;
					end
				end
				st_sending: begin
					if (!tx_en) begin
						state <= st_idle;  // an abort counts as an end of frame for the collector
						tx_line <= idle_level;
					end else if (bit_tick) begin
						if (frame_done) begin
							state <= st_idle;  // stop bit has run its full width
							tx_line <= idle_level;
						end else begin
							tx_line <= frame[bit_index];
							bit_index <= bit_index + index_width'(1);
						end
					end
				end
				default: begin
					state <= st_idle;
					tx_line <= idle_level;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verification/uart_tx_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_array_tb;
	import uart_frame_pkg::*;
	import uart_baud_pkg::*;

	// three address bits leave addresses 4 to 7 out of range
	localparam int num_channels = 4;
	localparam int chan_addr_width = 3;
	localparam logic [31:0] all_channels = (32'd1 << num_channels) - 32'd1;
	localparam int slow_select = 6;
	localparam int fast_select = 7;
	localparam int max_divisor = sample_divisor_table[slow_select];
	localparam int planned_frames = 8;
	localparam int cycle_limit = planned_frames * frame_bits * oversample * max_divisor + 2000;

	logic clk;
	logic reset;
	logic wr;
	logic [chan_addr_width-1:0] addr;
	logic [data_width-1:0] data;
	logic [baud_select_width-1:0] baud_select;
	logic [num_channels-1:0] tx_en;
	logic [num_channels-1:0] clear_done;
	logic [num_channels-1:0] tx_line;
	logic [num_channels-1:0] busy;
	logic [num_channels-1:0] done;
	logic irq;
	logic addr_error;

	int value_errors = 0;
	int other_errors = 0;
	int cycle_count;
	int frames_expected [num_channels] = '{default: 0};
	int frames_seen [num_channels] = '{default: 0};
	logic [data_width-1:0] expected_byte [num_channels];
	logic [15:0] lfsr_state;

	uart_tx_array #(
		.num_channels    (num_channels),
		.chan_addr_width (chan_addr_width)
	) u_uart_tx_array (
		.clk         (clk),
		.reset       (reset),
		.wr          (wr),
		.addr        (addr),
		.data        (data),
		.baud_select (baud_select),
		.tx_en       (tx_en),
		.clear_done  (clear_done),
		.tx_line     (tx_line),
		.busy        (busy),
		.done        (done),
		.irq         (irq),
		.addr_error  (addr_error)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// start 0, data lsb first, even parity, stop 1
	function automatic logic [frame_bits-1:0] frame_for(input logic [data_width-1:0] value);
		return {1'b1, ^value, value, 1'b0};
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_byte(output logic [data_width-1:0] value);
		for (int k = 0; k < data_width; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value[k] = lfsr_state[0];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	// busy is seen 2 cycles after the write when the channel takes it
	task automatic send_byte(input int target, input logic [data_width-1:0] value,
		input logic expect_take);
		wr = 1'b1;
		addr = chan_addr_width'(target);
		data = value;
		@(negedge clk);
		wr = 1'b0;
		@(negedge clk);
		if (expect_take) begin
			check_value($sformatf("busy[%0d]", target), 32'd1, 32'(busy[target]));
			expected_byte[target] = value;
			frames_expected[target]++;
		end
	endtask

	task automatic wait_idle(input int ch);
		int waited;
		int limit;
		waited = 0;
		limit = (frame_bits + 1) * int'(oversample * sample_divisor_table[baud_select]) + 4;
		while (busy[ch] && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		assert (!busy[ch]) else begin
			$display("channel %0d did not finish its frame within %0d cycles", ch, limit);
			other_errors++;
		end
	endtask

	// --------------------
	// frame monitors
	// --------------------
	for (genvar c = 0; c < num_channels; c++) begin : g_monitor
		initial begin
			logic [frame_bits-1:0] got;
			int bit_width;
			int elapsed;
			int taken;
			forever begin
				@(negedge clk);
				if (!reset && busy[c] && !tx_line[c]) begin
					bit_width = int'(oversample * sample_divisor_table[baud_select]);
					got = '0;
					elapsed = 0;
					taken = 0;
					while (busy[c] && elapsed <= frame_bits * bit_width) begin
						if (taken < frame_bits && elapsed == bit_width / 2 + taken * bit_width) begin
							got[taken] = tx_line[c];  // middle of the bit
							taken++;
						end
						@(negedge clk);
						elapsed++;
					end
					assert (elapsed == frame_bits * bit_width) else begin
						$display("FAIL %0t busy[%0d] frame cycles expected %0d actual %0d",
							$time, c, frame_bits * bit_width, elapsed);
						value_errors++;
					end
					assert (got == frame_for(expected_byte[c])) else begin
						$display("FAIL %0t tx_line[%0d] expected %h actual %h",
							$time, c, frame_for(expected_byte[c]), got);
						value_errors++;
					end
					frames_seen[c]++;
					@(negedge clk);
					assert (done[c]) else begin
						$display("FAIL %0t done[%0d] expected 1 actual 0", $time, c);
						value_errors++;
					end
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) &(busy | tx_line)) else begin
		$display("FAIL %0t tx_line expected %b actual %b", $time,
			$sampled(tx_line | ~busy), $sampled(tx_line));
		value_errors++;
	end

	assert property (@(posedge clk) disable iff (reset) irq == $past(|done)) else begin
		$display("FAIL %0t irq expected %0b actual %0b", $time, !$sampled(irq), $sampled(irq));
		value_errors++;
	end

	assert property (@(posedge clk) disable iff (reset) !$past(addr_error) || addr_error) else begin
		$display("FAIL %0t addr_error expected 1 actual 0", $time);
		value_errors++;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run stopped after %0d cycles without finishing the tests", cycle_count);
		$display("%0d value errors, %0d other errors", value_errors, other_errors);
		$display("Test failed");
		$finish;
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		logic [data_width-1:0] value;
		reset = 1'b1;
		wr = 1'b0;
		addr = '0;
		data = '0;
		baud_select = baud_select_width'(fast_select);
		tx_en = '1;
		clear_done = '0;
		lfsr_state = 16'd6;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value("tx_line", all_channels, 32'(tx_line));
		check_value("busy", 32'd0, 32'(busy));
		check_value("done", 32'd0, 32'(done));
		check_value("irq", 32'd0, 32'(irq));
		check_value("addr_error", 32'd0, 32'(addr_error));

		for (int ch = 0; ch < num_channels; ch++) begin
			random_byte(value);
			send_byte(ch, value, 1'b1);
		end
		for (int ch = 0; ch < num_channels; ch++) begin
			wait_idle(ch);
		end
		@(negedge clk);
		check_value("done", all_channels, 32'(done));
		@(negedge clk);
		check_value("irq", 32'd1, 32'(irq));

		clear_done = num_channels'(32'h5);  // one cycle mask pulse
		@(negedge clk);
		clear_done = '0;
		check_value("done", all_channels & ~32'h5, 32'(done));
		check_value("irq", 32'd1, 32'(irq));
		clear_done = num_channels'(all_channels & ~32'h5);
		@(negedge clk);
		clear_done = '0;
		check_value("done", 32'd0, 32'(done));
		@(negedge clk);
		check_value("irq", 32'd0, 32'(irq));

		random_byte(value);
		send_byte(1, value, 1'b1);
		repeat (5) @(negedge clk);
		random_byte(value);
		send_byte(1, value, 1'b0);  // channel 1 is mid frame
		wait_idle(1);
		repeat (frame_bits * oversample * sample_divisor_table[baud_select]) @(negedge clk);
		check_value("busy", 32'd0, 32'(busy));

		tx_en[2] = 1'b0;
		random_byte(value);
		send_byte(2, value, 1'b0);
		repeat (3) @(negedge clk);
		check_value("busy[2]", 32'd0, 32'(busy[2]));
		tx_en[2] = 1'b1;

		random_byte(value);
		send_byte(num_channels + 1, value, 1'b0);
		check_value("addr_error", 32'd1, 32'(addr_error));
		check_value("busy", 32'd0, 32'(busy));

		baud_select = baud_select_width'(slow_select);
		repeat (4) @(negedge clk);
		random_byte(value);
		send_byte(0, value, 1'b1);
		wait_idle(0);
		repeat (3) @(negedge clk);

		for (int ch = 0; ch < num_channels; ch++) begin
			assert (frames_seen[ch] == frames_expected[ch]) else begin
				$display("channel %0d sent %0d frames but %0d writes were taken",
					ch, frames_seen[ch], frames_expected[ch]);
				other_errors++;
			end
		end
		$display("%0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
